// File: hdl/dram_pkg.sv
`default_nettype none

package dram_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths shared by the arbiter and the memory port
  ////////////////////////////////////////////////////////////

  localparam int DATA_W = 144; // One memory word
  localparam int BE_W   = 18;  // One enable per byte of DATA_W
  localparam int ADDR_W = 32;  // Word address

  ////////////////////////////////////////////////////////////
  // Memory-port opcodes
  ////////////////////////////////////////////////////////////

  // Encoded so that the rnw flag casts directly to the opcode
  typedef enum logic {
    CMD_WRITE = 1'b0,
    CMD_READ  = 1'b1
  } cmd_op_t;

endpackage

`default_nettype wire

// File: hdl/arb_pkg.sv
`default_nettype none

package arb_pkg;

  // One-hot so each ack is a single state bit
  typedef enum logic [2:0] {
    ARB_REQ0 = 3'b001,
    ARB_REQ1 = 3'b010,
    ARB_WAIT = 3'b100
  } arb_state_t;

  // Requester tag kept per outstanding read
  typedef enum logic {
    REQ_0 = 1'b0,
    REQ_1 = 1'b1
  } req_sel_t;

endpackage

`default_nettype wire

// File: hdl/read_history_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module read_history_fifo
  import arb_pkg::*;
#(
  parameter int DEPTH = 128
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     wr_en,
  input  req_sel_t wr_data,
  input  logic     rd_en,
  output req_sel_t rd_data,
  output logic     empty,
  output logic     full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  req_sel_t         tag_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign push    = wr_en && !full;
  assign pop     = rd_en && !empty;
  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(DEPTH));
  assign rd_data = tag_mem[rd_ptr]; // Head falls through

  always_ff @(posedge clk) begin
    if (push) begin
      tag_mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // Wrap
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Both or neither
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr_en |-> !full)
    else $error("read history overflow");

  a_no_underflow: assert property (@(posedge clk) disable iff (rst) rd_en |-> !empty)
    else $error("read history underflow");

endmodule

`default_nettype wire

// File: hdl/dram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module dram_arbiter
  import dram_pkg::*;
  import arb_pkg::*;
#(
  parameter int HIST_DEPTH = 128
) (
  input  logic              clk,
  input  logic              rst,

  output logic [ADDR_W-1:0] mem_cmd_addr,
  output logic              mem_cmd_rnw,
  output logic              mem_cmd_valid,
  output logic [DATA_W-1:0] mem_wr_data,
  output logic [BE_W-1:0]   mem_wr_be,
  input  logic [DATA_W-1:0] mem_rd_data,
  input  logic              mem_rd_valid,
  input  logic              mem_fifo_ready,

  input  logic [ADDR_W-1:0] req0_cmd_addr,
  input  logic              req0_cmd_rnw,
  input  logic              req0_cmd_valid,
  input  logic [DATA_W-1:0] req0_wr_data,
  input  logic [BE_W-1:0]   req0_wr_be,
  output logic [DATA_W-1:0] req0_rd_data,
  output logic              req0_rd_valid,
  output logic              req0_ack,

  input  logic [ADDR_W-1:0] req1_cmd_addr,
  input  logic              req1_cmd_rnw,
  input  logic              req1_cmd_valid,
  input  logic [DATA_W-1:0] req1_wr_data,
  input  logic [BE_W-1:0]   req1_wr_be,
  output logic [DATA_W-1:0] req1_rd_data,
  output logic              req1_rd_valid,
  output logic              req1_ack
);

  arb_state_t state;
  req_sel_t   last_served; // Tie breaker for ARB_WAIT
  req_sel_t   grant_sel;
  cmd_op_t    grant_op;
  logic       hist_push;
  req_sel_t   hist_head;
  logic       hist_empty;
  logic       hist_full;
  logic       first_beat;  // Next rd_valid starts a burst
  req_sel_t   burst_tag;   // Owner of the burst in flight
  req_sel_t   rd_tag;

  ////////////////////////////////////////////////////////////
  // Grant state machine
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= ARB_REQ0;
      last_served <= REQ_1; // First tie goes to requester 0
    end else begin
      if (req0_ack && req0_cmd_valid) begin
        last_served <= REQ_0;
      end else if (req1_ack && req1_cmd_valid) begin
        last_served <= REQ_1;
      end

      case (state)
        ARB_REQ0: begin
          if (!mem_fifo_ready || req0_cmd_valid) begin
            state <= ARB_WAIT; // One command per grant
          end else if (req1_cmd_valid) begin
            state <= ARB_REQ1;
          end
        end
        ARB_REQ1: begin
          if (!mem_fifo_ready || req1_cmd_valid) begin
            state <= ARB_WAIT;
          end else if (req0_cmd_valid) begin
            state <= ARB_REQ0;
          end
        end
        ARB_WAIT: begin
          if (mem_fifo_ready) begin
            case ({req1_cmd_valid, req0_cmd_valid})
              2'b01:   state <= ARB_REQ0;
              2'b10:   state <= ARB_REQ1;
              2'b11:   state <= (last_served == REQ_0) ? ARB_REQ1 : ARB_REQ0;
              default: state <= ARB_REQ0; // Idle
            endcase
          end
        end
        default: state <= ARB_REQ0;
      endcase
    end
  end

  assign req0_ack  = state[0]; // ARB_REQ0 bit
  assign req1_ack  = state[1]; // ARB_REQ1 bit
  assign grant_sel = req1_ack ? REQ_1 : REQ_0;

  ////////////////////////////////////////////////////////////
  // Command mux
  ////////////////////////////////////////////////////////////

  assign mem_cmd_valid = (req0_ack && req0_cmd_valid) || (req1_ack && req1_cmd_valid);
  assign mem_cmd_rnw   = (grant_sel == REQ_1) ? req1_cmd_rnw  : req0_cmd_rnw;
  assign mem_cmd_addr  = (grant_sel == REQ_1) ? req1_cmd_addr : req0_cmd_addr;
  assign mem_wr_data   = (grant_sel == REQ_1) ? req1_wr_data  : req0_wr_data;
  assign mem_wr_be     = (grant_sel == REQ_1) ? req1_wr_be    : req0_wr_be;

  assign grant_op  = cmd_op_t'(mem_cmd_rnw);
  assign hist_push = mem_cmd_valid && (grant_op == CMD_READ);

  ////////////////////////////////////////////////////////////
  // Read return steering
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      first_beat <= 1'b1;
    end else if (mem_rd_valid) begin
      first_beat <= !first_beat; // Bursts are always two beats
    end
  end

  always_ff @(posedge clk) begin
    if (mem_rd_valid && first_beat) begin
      burst_tag <= hist_head; // Kept for beat 1 after the pop
    end
  end

  read_history_fifo #(
    .DEPTH (HIST_DEPTH)
  ) read_history_fifo_inst (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (hist_push),
    .wr_data (grant_sel),
    .rd_en   (mem_rd_valid && first_beat),
    .rd_data (hist_head),
    .empty   (hist_empty),
    .full    (hist_full)
  );

  assign rd_tag        = first_beat ? hist_head : burst_tag;
  assign req0_rd_data  = mem_rd_data;
  assign req1_rd_data  = mem_rd_data;
  assign req0_rd_valid = mem_rd_valid && (rd_tag == REQ_0);
  assign req1_rd_valid = mem_rd_valid && (rd_tag == REQ_1);

  a_ack_onehot: assert property (@(posedge clk) disable iff (rst) !(req0_ack && req1_ack))
    else $error("both requesters granted");

  a_hist_room: assert property (@(posedge clk) disable iff (rst) hist_push |-> !hist_full)
    else $error("read issued with history full");

  a_hist_owner: assert property (@(posedge clk) disable iff (rst)
    mem_rd_valid && first_beat |-> !hist_empty)
    else $error("read data with no outstanding read");

endmodule

`default_nettype wire

// File: hdl/dram_port.sv
`timescale 1ns/1ps
`default_nettype none

module dram_port
  import dram_pkg::*;
#(
  parameter int QUEUE_DEPTH = 8,
  parameter int MEM_WORDS   = 64,
  parameter int READ_LAT    = 3
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [ADDR_W-1:0] cmd_addr,
  input  logic              cmd_rnw,
  input  logic              cmd_valid,
  input  logic [DATA_W-1:0] wr_data,
  input  logic [BE_W-1:0]   wr_be,
  output logic [DATA_W-1:0] rd_data,
  output logic              rd_valid,
  output logic              fifo_ready
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  cmd_op_t           q_op   [QUEUE_DEPTH];
  logic [ADDR_W-1:0] q_addr [QUEUE_DEPTH];
  logic [DATA_W-1:0] q_data [QUEUE_DEPTH];
  logic [BE_W-1:0]   q_be   [QUEUE_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              q_full;
  logic              enq;
  logic              deq;

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic [IDX_W-1:0]  head_idx;
  logic [DATA_W-1:0] merged;
  logic              head_read;
  logic              stall;     // Second-beat cycle, no dequeue
  logic [IDX_W-1:0]  beat1_idx;
  logic              gen_valid;
  logic [DATA_W-1:0] gen_data;
  logic [READ_LAT-1:0] pipe_valid;
  logic [DATA_W-1:0]   pipe_data [READ_LAT];

  ////////////////////////////////////////////////////////////
  // Command queue
  ////////////////////////////////////////////////////////////

  assign q_full     = (count == CNT_W'(QUEUE_DEPTH));
  assign enq        = cmd_valid && !q_full;
  assign deq        = (count != '0) && !stall;
  assign fifo_ready = (count <= CNT_W'(QUEUE_DEPTH - 2)); // Keep one spare slot

  always_ff @(posedge clk) begin
    if (enq) begin
      q_op[wr_ptr]   <= cmd_op_t'(cmd_rnw);
      q_addr[wr_ptr] <= cmd_addr;
      q_data[wr_ptr] <= wr_data;
      q_be[wr_ptr]   <= wr_be;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (enq) begin
        wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (deq) begin
        rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({enq, deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Executor and memory array
  ////////////////////////////////////////////////////////////

  assign head_idx  = IDX_W'(q_addr[rd_ptr] % MEM_WORDS); // Address counts words
  assign head_read = deq && (q_op[rd_ptr] == CMD_READ);

  always_comb begin
    for (int b = 0; b < BE_W; b++) begin
      merged[b*8 +: 8] = q_be[rd_ptr][b] ? q_data[rd_ptr][b*8 +: 8] : mem[head_idx][b*8 +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (deq && (q_op[rd_ptr] == CMD_WRITE)) begin
      mem[head_idx] <= merged;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read return
  ////////////////////////////////////////////////////////////

  // Beat 0 is sampled at dequeue, beat 1 in the stall cycle that
  // follows, so no later write can reach either word first
  always_ff @(posedge clk) begin
    if (head_read) begin
      beat1_idx <= (head_idx == IDX_W'(MEM_WORDS - 1)) ? '0 : head_idx + 1'b1;
    end
  end

  assign gen_valid = head_read || stall;
  assign gen_data  = head_read ? mem[head_idx] : mem[beat1_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      stall      <= 1'b0;
      pipe_valid <= '0;
    end else begin
      stall         <= head_read;
      pipe_valid[0] <= gen_valid;
      for (int i = 1; i < READ_LAT; i++) begin
        pipe_valid[i] <= pipe_valid[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    pipe_data[0] <= gen_data;
    for (int i = 1; i < READ_LAT; i++) begin
      pipe_data[i] <= pipe_data[i-1];
    end
  end

  assign rd_valid = pipe_valid[READ_LAT-1];
  assign rd_data  = pipe_data[READ_LAT-1];

  a_no_enq_full: assert property (@(posedge clk) disable iff (rst) cmd_valid |-> !q_full)
    else $error("command dropped, queue full");

endmodule

`default_nettype wire

// File: hdl/dram_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module dram_subsystem_top
  import dram_pkg::*;
#(
  parameter int HIST_DEPTH  = 128,
  parameter int QUEUE_DEPTH = 8,
  parameter int MEM_WORDS   = 64,
  parameter int READ_LAT    = 3
) (
  input  logic              clk,
  input  logic              rst,

  input  logic [ADDR_W-1:0] req0_cmd_addr,
  input  logic              req0_cmd_rnw,
  input  logic              req0_cmd_valid,
  input  logic [DATA_W-1:0] req0_wr_data,
  input  logic [BE_W-1:0]   req0_wr_be,
  output logic [DATA_W-1:0] req0_rd_data,
  output logic              req0_rd_valid,
  output logic              req0_ack,

  input  logic [ADDR_W-1:0] req1_cmd_addr,
  input  logic              req1_cmd_rnw,
  input  logic              req1_cmd_valid,
  input  logic [DATA_W-1:0] req1_wr_data,
  input  logic [BE_W-1:0]   req1_wr_be,
  output logic [DATA_W-1:0] req1_rd_data,
  output logic              req1_rd_valid,
  output logic              req1_ack
);

  logic [ADDR_W-1:0] mem_cmd_addr;
  logic              mem_cmd_rnw;
  logic              mem_cmd_valid;
  logic [DATA_W-1:0] mem_wr_data;
  logic [BE_W-1:0]   mem_wr_be;
  logic [DATA_W-1:0] mem_rd_data;
  logic              mem_rd_valid;
  logic              mem_fifo_ready;

  dram_arbiter #(
    .HIST_DEPTH (HIST_DEPTH)
  ) dram_arbiter_inst (
    .clk            (clk),
    .rst            (rst),
    .mem_cmd_addr   (mem_cmd_addr),
    .mem_cmd_rnw    (mem_cmd_rnw),
    .mem_cmd_valid  (mem_cmd_valid),
    .mem_wr_data    (mem_wr_data),
    .mem_wr_be      (mem_wr_be),
    .mem_rd_data    (mem_rd_data),
    .mem_rd_valid   (mem_rd_valid),
    .mem_fifo_ready (mem_fifo_ready),
    .req0_cmd_addr  (req0_cmd_addr),
    .req0_cmd_rnw   (req0_cmd_rnw),
    .req0_cmd_valid (req0_cmd_valid),
    .req0_wr_data   (req0_wr_data),
    .req0_wr_be     (req0_wr_be),
    .req0_rd_data   (req0_rd_data),
    .req0_rd_valid  (req0_rd_valid),
    .req0_ack       (req0_ack),
    .req1_cmd_addr  (req1_cmd_addr),
    .req1_cmd_rnw   (req1_cmd_rnw),
    .req1_cmd_valid (req1_cmd_valid),
    .req1_wr_data   (req1_wr_data),
    .req1_wr_be     (req1_wr_be),
    .req1_rd_data   (req1_rd_data),
    .req1_rd_valid  (req1_rd_valid),
    .req1_ack       (req1_ack)
  );

  dram_port #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .MEM_WORDS   (MEM_WORDS),
    .READ_LAT    (READ_LAT)
  ) dram_port_inst (
    .clk        (clk),
    .rst        (rst),
    .cmd_addr   (mem_cmd_addr),
    .cmd_rnw    (mem_cmd_rnw),
    .cmd_valid  (mem_cmd_valid),
    .wr_data    (mem_wr_data),
    .wr_be      (mem_wr_be),
    .rd_data    (mem_rd_data),
    .rd_valid   (mem_rd_valid),
    .fifo_ready (mem_fifo_ready)
  );

endmodule

`default_nettype wire

// File: tests/tb_dram_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dram_subsystem
  import dram_pkg::*;
();

  localparam int HIST_DEPTH  = 128;
  localparam int QUEUE_DEPTH = 2;  // Ready drops with one entry queued
  localparam int MEM_WORDS   = 64;
  localparam int READ_LAT    = 3;
  localparam int N_RAND      = 40; // Commands per requester in test 5
  localparam int TOTAL_CMDS  = 4 + 12 + 8 + 16 + 2 * N_RAND;
  localparam int TIMEOUT_CYC = 20 * TOTAL_CMDS + 200;

  logic                   clk;
  logic                   rst;
  logic [1:0]             cmd_valid;
  logic [1:0]             cmd_rnw;
  logic [1:0][ADDR_W-1:0] cmd_addr;
  logic [1:0][DATA_W-1:0] wr_data;
  logic [1:0][BE_W-1:0]   wr_be;
  wire  [1:0]             ack;
  wire  [1:0]             rd_valid;
  wire  [1:0][DATA_W-1:0] rd_data;

  logic [DATA_W-1:0] ref_mem [MEM_WORDS]; // Updated in transfer order
  logic [DATA_W-1:0] exp_q0 [$];
  logic [DATA_W-1:0] exp_q1 [$];
  logic              r_rnw  [2][N_RAND];
  logic [ADDR_W-1:0] r_addr [2][N_RAND];
  logic [DATA_W-1:0] r_data [2][N_RAND];
  logic [BE_W-1:0]   r_be   [2][N_RAND];
  int   seed = 32'hbbccc7ef;
  int   errors = 0;
  int   checks = 0;
  int   cycles = 0;
  int   xfers [2];
  int   last_xfer = -1;
  logic other_waited = 1'b0; // Other requester held a command at last transfer

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  dram_subsystem_top #(
    .HIST_DEPTH  (HIST_DEPTH),
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .MEM_WORDS   (MEM_WORDS),
    .READ_LAT    (READ_LAT)
  ) dram_subsystem_top_inst (
    .clk (clk), .rst (rst),
    .req0_cmd_addr (cmd_addr[0]), .req0_cmd_rnw (cmd_rnw[0]), .req0_cmd_valid (cmd_valid[0]),
    .req0_wr_data (wr_data[0]), .req0_wr_be (wr_be[0]),
    .req0_rd_data (rd_data[0]), .req0_rd_valid (rd_valid[0]), .req0_ack (ack[0]),
    .req1_cmd_addr (cmd_addr[1]), .req1_cmd_rnw (cmd_rnw[1]), .req1_cmd_valid (cmd_valid[1]),
    .req1_wr_data (wr_data[1]), .req1_wr_be (wr_be[1]),
    .req1_rd_data (rd_data[1]), .req1_rd_valid (rd_valid[1]), .req1_ack (ack[1])
  );

  ////////////////////////////////////////////////////////////
  // Reference model and checkers
  ////////////////////////////////////////////////////////////

  function automatic logic [DATA_W-1:0] expected_beat(input logic [ADDR_W-1:0] addr,
                                                      input int beat);
    int idx;
    idx = (int'(addr % MEM_WORDS) + beat) % MEM_WORDS; // Beat 1 wraps to word 0
    return ref_mem[idx];
  endfunction

  task automatic check(input string name, input logic [DATA_W-1:0] got,
                       input logic [DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic record_transfer(input int r);
    int idx;
    if (last_xfer == r && other_waited) begin
      report_error($sformatf("requester %0d granted twice while requester %0d waited", r, 1 - r));
    end
    last_xfer    = r;
    other_waited = cmd_valid[1-r];
    xfers[r]++;
    idx = int'(cmd_addr[r] % MEM_WORDS);
    if (cmd_rnw[r]) begin
      if (r == 0) begin
        exp_q0.push_back(expected_beat(cmd_addr[r], 0));
        exp_q0.push_back(expected_beat(cmd_addr[r], 1));
      end else begin
        exp_q1.push_back(expected_beat(cmd_addr[r], 0));
        exp_q1.push_back(expected_beat(cmd_addr[r], 1));
      end
    end else begin
      for (int b = 0; b < BE_W; b++) begin
        if (wr_be[r][b]) begin
          ref_mem[idx][b*8 +: 8] = wr_data[r][b*8 +: 8]; // Byte merge
        end
      end
    end
  endtask

  // Sampled mid-cycle between the edges
  always @(negedge clk) begin
    if (!rst) begin
      for (int r = 0; r < 2; r++) begin
        if (cmd_valid[r] && ack[r]) begin
          record_transfer(r);
        end
      end
      if (rd_valid[0] && rd_valid[1]) begin
        report_error("read data steered to both requesters in one cycle");
      end
      if (rd_valid[0]) begin
        if (exp_q0.size() == 0) begin
          report_error("stray read beat on requester 0");
        end else begin
          check("req0_rd_data", rd_data[0], exp_q0.pop_front());
        end
      end
      if (rd_valid[1]) begin
        if (exp_q1.size() == 0) begin
          report_error("stray read beat on requester 1");
        end else begin
          check("req1_rd_data", rd_data[1], exp_q1.pop_front());
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYC) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Requester drivers
  ////////////////////////////////////////////////////////////

  // Runs from 1 ns after a rising edge to 1 ns after the transfer edge
  task automatic issue(input int r, input logic rnw, input logic [ADDR_W-1:0] addr,
                       input logic [DATA_W-1:0] data, input logic [BE_W-1:0] be);
    cmd_valid[r] = 1'b1;
    cmd_rnw[r]   = rnw;
    cmd_addr[r]  = addr;
    wr_data[r]   = data;
    wr_be[r]     = be;
    do begin
      @(negedge clk);
    end while (!ack[r]);
    @(posedge clk);
    #1;
    cmd_valid[r] = 1'b0;
  endtask

  function automatic logic [DATA_W-1:0] rand_word();
    logic [159:0] w;
    for (int i = 0; i < 5; i++) begin
      w[i*32 +: 32] = $random(seed);
    end
    return w[DATA_W-1:0];
  endfunction

  task automatic wait_drain();
    while (exp_q0.size() != 0 || exp_q1.size() != 0) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic run_burst(input int r);
    for (int i = 0; i < 8; i++) begin
      issue(r, i[0], ADDR_W'((r * 16 + i * 3) % MEM_WORDS), {18{8'(8'h50 + r * 8 + i)}}, '1);
    end
  endtask

  task automatic run_random(input int r);
    for (int i = 0; i < N_RAND; i++) begin
      issue(r, r_rnw[r][i], r_addr[r][i], r_data[r][i], r_be[r][i]);
    end
  endtask

  task automatic report_test(input int num, input string name, input int err_mark);
    $display("test %0d %s: done, %0d errors", num, name, errors - err_mark);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int err_mark;
    rst       = 1'b1;
    cmd_valid = '0;
    cmd_rnw   = '0;
    cmd_addr  = '0;
    wr_data   = '0;
    wr_be     = '0;
    xfers[0]  = 0;
    xfers[1]  = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    // Test 1 reads untouched words back as zero
    err_mark = errors;
    @(negedge clk);
    check("req0_ack", ack[0], 1'b1);
    check("req1_ack", ack[1], 1'b0);
    check("req0_rd_valid", rd_valid[0], 1'b0);
    check("req1_rd_valid", rd_valid[1], 1'b0);
    @(posedge clk);
    #1;
    fork
      begin
        issue(0, 1'b1, 20, '0, '0);
        issue(0, 1'b1, 41, '0, '0);
      end
      begin
        issue(1, 1'b1, 30, '0, '0);
        issue(1, 1'b1, MEM_WORDS - 1, '0, '0);
      end
    join
    wait_drain();
    repeat (10) @(posedge clk); // Idle so any beat here is stray
    #1;
    report_test(1, "reads after reset", err_mark);

    // Test 2 writes full words then reads them from requester 0
    err_mark = errors;
    for (int i = 0; i < 6; i++) begin
      issue(0, 1'b0, ADDR_W'((i * 13 + 11) % MEM_WORDS), rand_word(), '1);
    end
    for (int i = 0; i < 6; i++) begin
      issue(0, 1'b1, ADDR_W'((i * 13 + 11) % MEM_WORDS), '0, '0);
    end
    wait_drain();
    report_test(2, "full writes and reads", err_mark);

    // Test 3 merges partial byte enables with the old word
    err_mark = errors;
    issue(0, 1'b0, 40, rand_word(), '1);
    issue(1, 1'b0, 40, rand_word(), 18'h0f0f3);
    issue(0, 1'b0, 41, rand_word(), 18'h20001);
    issue(1, 1'b0, 11, rand_word(), 18'h3c000);
    issue(0, 1'b1, 40, '0, '0);
    issue(1, 1'b1, 40, '0, '0);
    issue(0, 1'b1, 11, '0, '0);
    issue(1, 1'b1, 11, '0, '0);
    wait_drain();
    report_test(3, "byte-enable merge", err_mark);

    // Test 4 has both requesters hold commands back to back
    err_mark = errors;
    fork
      run_burst(0);
      run_burst(1);
    join
    wait_drain();
    report_test(4, "alternating grants", err_mark);

    // Test 5 sends random traffic with addresses past MEM_WORDS
    err_mark = errors;
    for (int r = 0; r < 2; r++) begin
      for (int i = 0; i < N_RAND; i++) begin
        r_rnw[r][i]  = ($random(seed) % 2) != 0;
        r_addr[r][i] = $unsigned($random(seed)) % 96;
        r_data[r][i] = rand_word();
        r_be[r][i]   = BE_W'($random(seed));
      end
    end
    fork
      run_random(0);
      run_random(1);
    join
    wait_drain();
    report_test(5, "random traffic", err_mark);

    $display("checks %0d, errors %0d, transfers %0d", checks, errors, xfers[0] + xfers[1]);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
hdl/dram_pkg.sv
hdl/arb_pkg.sv
hdl/read_history_fifo.sv
hdl/dram_arbiter.sv
hdl/dram_port.sv
hdl/dram_subsystem_top.sv
tests/tb_dram_subsystem.sv

// File: Bender.yml
package:
  name: dram_subsystem

sources:
  # Packages first, then leaf modules, then the top level
  - files:
      - hdl/dram_pkg.sv
      - hdl/arb_pkg.sv
      - hdl/read_history_fifo.sv
      - hdl/dram_arbiter.sv
      - hdl/dram_port.sv
      - hdl/dram_subsystem_top.sv

  - target: test
    files:
      - tests/tb_dram_subsystem.sv
